// ==== project.f ====
+incdir+include
src/decode_pkg.sv
src/imm_gen.sv
src/decoder.sv
src/decode_queue.sv
src/decode_stage.sv
test/decode_tb.sv

// ==== Makefile ====
TOP = decode_tb

compile:
	verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module $(TOP) -Mdir obj_dir

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: compile run clean

// ==== test/decode_tb.sv ====
`timescale 1ns/1ps
`include "sys_defs.svh"

module decode_tb;

	localparam logic [1:0] kind_ok = 2'd0;
	localparam logic [1:0] kind_csr = 2'd1;
	localparam logic [1:0] kind_wfi = 2'd2;
	localparam logic [1:0] kind_bad = 2'd3;
	localparam logic [31:0] wfi_word = 32'h10500073;

	logic clock;
	logic rst_n;
	logic in_valid;
	decode_pkg::inst_t inst;
	logic [`XLEN-1:0] in_pc;
	logic flush;
	logic dispatch_en;
	logic full;
	logic head_valid;
	decode_pkg::decoded_pack_t head;
	logic csr_op;
	logic halt;
	logic illegal;

	decode_pkg::decoded_pack_t model_q[$];
	logic model_halted;
	logic [31:0] rng;
	logic [31:0] pc;
	int checks;
	int errors;
	int timeouts;

	decode_stage dut (
		.clock       (clock),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.inst        (inst),
		.in_pc       (in_pc),
		.flush       (flush),
		.dispatch_en (dispatch_en),
		.full        (full),
		.head_valid  (head_valid),
		.head        (head),
		.csr_op      (csr_op),
		.halt        (halt),
		.illegal     (illegal)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] v;
		v = x ^ (x << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic [31:0] addi_word(input logic [31:0] b);
		return {b[31:15], 3'b000, b[11:7], 7'b0010011};
	endfunction

	// a picks the class and b fills the fields
	function automatic logic [31:0] random_inst(input logic [31:0] a, input logic [31:0] b);
		logic [6:0] f7;
		logic [2:0] f3;
		logic [2:0] csr_f3;
		f7 = (a[5:4] == 2'd0) ? 7'b0100000 : (a[5:4] == 2'd1) ? 7'b0000001 : 7'b0000000;
		f3 = b[14:12];
		csr_f3 = (b[13:12] == 2'd0) ? 3'b001 : {1'b0, b[13:12]};
		case (a[3:0])
			4'd0: return {b[31:12], b[11:7], 7'b0110111};
			4'd1: return {b[31:12], b[11:7], 7'b0010111};
			4'd2: return {b[31:12], b[11:7], 7'b1101111};
			4'd3: return {b[31:15], 3'b000, b[11:7], 7'b1100111};
			4'd4: return {b[31:7], 7'b1100011};
			4'd5: return {b[31:7], 7'b0000011};
			4'd6: return {b[31:7], 7'b0100011};
			// shifts need a sane funct7 while other ops keep random immediate bits
			4'd7: return {(f3 == 3'b001 || f3 == 3'b101) ? f7 : b[31:25], b[24:7], 7'b0010011};
			4'd8, 4'd9: return {f7, b[24:7], 7'b0110011};
			4'd10: begin
				if (a[9:6] == 4'd0)
					return wfi_word;
				return {b[31:15], csr_f3, b[11:7], 7'b1110011};
			end
			default: return b;
		endcase
	endfunction

	// reference decode straight from the RV32IM field layout
	function automatic void ref_decode(
		input logic [31:0] w,
		input logic [31:0] pc_in,
		output decode_pkg::decoded_pack_t p,
		output logic [1:0] kind
	);
		logic [2:0] f3;
		logic [6:0] f7;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		f3 = w[14:12];
		f7 = w[31:25];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		p = '0;
		p.pc = pc_in;
		p.fu = decode_pkg::FU_ALU;
		p.func = decode_pkg::ALU_ADD;
		kind = kind_ok;
		// i-format defaults that the other formats override below
		p.arch_reg.src1 = w[19:15];
		p.arch_reg.dest = w[11:7];
		p.rs1_valid = 1'b1;
		p.imm = imm_i;
		p.imm_valid = 1'b1;
		case (w[6:0])
			7'b0110111, 7'b0010111, 7'b1101111: begin
				p.arch_reg.src1 = '0;
				p.rs1_valid = 1'b0;
				p.imm = {w[31:12], 12'b0};
				p.pc_valid = (w[6:0] != 7'b0110111);
				if (w[6:0] == 7'b1101111) begin
					p.fu = decode_pkg::FU_BTU;
					p.func = decode_pkg::BTU_JAL;
					p.imm = imm_j;
				end
			end
			7'b1100111: begin
				p.fu = decode_pkg::FU_BTU;
				p.func = decode_pkg::BTU_JALR;
				p.pc_valid = 1'b1;
				if (f3 != 3'b000)
					kind = kind_bad;
			end
			7'b1100011, 7'b0100011: begin
				p.arch_reg.src2 = w[24:20];
				p.arch_reg.dest = '0;
				p.rs2_valid = 1'b1;
				if (w[6:0] == 7'b1100011) begin
					p.fu = decode_pkg::FU_BTU;
					p.imm = imm_b;
					p.pc_valid = 1'b1;
					case (f3)
						3'd0: p.func = decode_pkg::BTU_BEQ;
						3'd1: p.func = decode_pkg::BTU_BNE;
						3'd4: p.func = decode_pkg::BTU_BLT;
						3'd5: p.func = decode_pkg::BTU_BGE;
						3'd6: p.func = decode_pkg::BTU_BLTU;
						3'd7: p.func = decode_pkg::BTU_BGEU;
						default: kind = kind_bad;
					endcase
				end else begin
					p.fu = decode_pkg::FU_LSU;
					p.imm = imm_s;
					case (f3)
						3'd0: p.func = decode_pkg::LSU_SB;
						3'd1: p.func = decode_pkg::LSU_SH;
						3'd2: p.func = decode_pkg::LSU_SW;
						default: kind = kind_bad;
					endcase
				end
			end
			7'b0000011: begin
				p.fu = decode_pkg::FU_LSU;
				case (f3)
					3'd0: p.func = decode_pkg::LSU_LB;
					3'd1: p.func = decode_pkg::LSU_LH;
					3'd2: p.func = decode_pkg::LSU_LW;
					3'd4: p.func = decode_pkg::LSU_LBU;
					3'd5: p.func = decode_pkg::LSU_LHU;
					default: kind = kind_bad;
				endcase
			end
			7'b0010011, 7'b0110011: begin
				if (w[5]) begin
					// register form has no immediate
					p.arch_reg.src2 = w[24:20];
					p.rs2_valid = 1'b1;
					p.imm = '0;
					p.imm_valid = 1'b0;
				end
				case (f3)
					3'd0: p.func = (w[5] && f7 == 7'b0100000) ? decode_pkg::ALU_SUB
						: decode_pkg::ALU_ADD;
					3'd1: p.func = decode_pkg::ALU_SLL;
					3'd2: p.func = decode_pkg::ALU_SLT;
					3'd3: p.func = decode_pkg::ALU_SLTU;
					3'd4: p.func = decode_pkg::ALU_XOR;
					3'd5: p.func = f7[5] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
					3'd6: p.func = decode_pkg::ALU_OR;
					default: p.func = decode_pkg::ALU_AND;
				endcase
				if (w[5] && f7 == 7'b0000001) begin
					p.fu = decode_pkg::FU_MULT;
					case (f3)
						3'd0: p.func = decode_pkg::MULT_MUL;
						3'd1: p.func = decode_pkg::MULT_MULH;
						3'd2: p.func = decode_pkg::MULT_MULHSU;
						3'd3: p.func = decode_pkg::MULT_MULHU;
						default: kind = kind_bad;
					endcase
				end else if (w[5] || f3 == 3'd1 || f3 == 3'd5) begin
					// funct7 must be zero except 0100000 for sub and arithmetic shifts
					if (f7 == 7'b0100000 && !(f3 == 3'd5 || (w[5] && f3 == 3'd0)))
						kind = kind_bad;
					else if (f7 != 7'b0100000 && f7 != 7'b0000000)
						kind = kind_bad;
				end
			end
			7'b1110011: begin
				p.fu = decode_pkg::FU_SYS;
				if (f3 >= 3'd1 && f3 <= 3'd3) begin
					kind = kind_csr;
				end else begin
					kind = (w == wfi_word) ? kind_wfi : kind_bad;
					p.arch_reg = '0;
					p.rs1_valid = 1'b0;
					p.imm = '0;
					p.imm_valid = 1'b0;
				end
			end
			default: kind = kind_bad;
		endcase
	endfunction

	task automatic check_pack(
		input decode_pkg::decoded_pack_t expected,
		input decode_pkg::decoded_pack_t actual
	);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: head packet expected %h, got %h", $time, expected, actual);
		end
	endtask

	// order is csr_op, halt, illegal
	task automatic check_flags(input logic [2:0] expected, input logic [2:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: status pulses expected %b, got %b", $time, expected, actual);
		end
	endtask

	// order is full, head_valid
	task automatic check_levels(input logic [1:0] expected, input logic [1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: queue levels expected %b, got %b", $time, expected, actual);
		end
	endtask

	task automatic apply_inputs(
		input logic v,
		input logic [31:0] w,
		input logic fl,
		input logic de
	);
		in_valid = v;
		inst = w;
		in_pc = pc;
		flush = fl;
		dispatch_en = de;
		pc = pc + 32'd4;
	endtask

	// one edge updates the model from the inputs it saw and then compares
	task automatic advance_cycle();
		decode_pkg::decoded_pack_t p;
		logic [1:0] kind;
		logic accept;
		logic [2:0] exp_flags;
		@(posedge clock);
		#1;
		accept = in_valid && model_q.size() < `DQ_DEPTH && !model_halted && !flush;
		ref_decode(inst, in_pc, p, kind);
		exp_flags = {accept && kind == kind_csr, accept && kind == kind_wfi,
			accept && kind == kind_bad};
		if (flush) begin
			model_q.delete();
			model_halted = 1'b0;
		end else begin
			if (dispatch_en && model_q.size() != 0)
				void'(model_q.pop_front());
			if (accept && kind != kind_bad)
				model_q.push_back(p);
			if (accept && kind == kind_wfi)
				model_halted = 1'b1;
		end
		check_flags(exp_flags, {csr_op, halt, illegal});
		check_levels({model_q.size() == `DQ_DEPTH, model_q.size() != 0}, {full, head_valid});
		if (model_q.size() != 0)
			check_pack(model_q[0], head);
	endtask

	initial begin
		logic [31:0] a;
		int n;
		rng = 32'd54345;
		pc = 32'h0000_1000;
		checks = 0;
		errors = 0;
		timeouts = 0;
		model_halted = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		inst = '0;
		in_pc = '0;
		flush = 1'b0;
		dispatch_en = 1'b0;
		repeat (10) @(posedge clock);
		#1;
		rst_n = 1'b1;
		check_levels(2'b00, {full, head_valid});
		check_flags(3'b000, {csr_op, halt, illegal});

		// random traffic with occasional back-pressure and rare flush
		for (int i = 0; i < 4000; i++) begin
			rng = xorshift(rng);
			a = rng;
			rng = xorshift(rng);
			apply_inputs(a[31:30] != 2'd0, random_inst(a, rng), a[29:24] == 6'd0, a[23:21] < 3'd4);
			advance_cycle();
		end

		// fill under back-pressure and hold before draining
		apply_inputs(1'b0, '0, 1'b1, 1'b0);
		advance_cycle();
		n = 0;
		while (!full && n < 4 * `DQ_DEPTH) begin
			rng = xorshift(rng);
			apply_inputs(1'b1, addi_word(rng), 1'b0, 1'b0);
			advance_cycle();
			n++;
		end
		if (!full) begin
			timeouts++;
			$display("timeout: queue never became full under back-pressure");
		end else if (n != `DQ_DEPTH) begin
			errors++;
			$display("ERROR at %0t: full rose after %0d pushes", $time, n);
		end
		repeat (6) begin
			rng = xorshift(rng);
			apply_inputs(1'b1, addi_word(rng), 1'b0, 1'b0);
			advance_cycle();
		end
		n = 0;
		while (head_valid && n < 4 * `DQ_DEPTH) begin
			apply_inputs(1'b0, '0, 1'b0, 1'b1);
			advance_cycle();
			n++;
		end
		if (head_valid) begin
			timeouts++;
			$display("timeout: queue did not drain with dispatch enabled");
		end

		// wfi halts the stage until a flush
		apply_inputs(1'b1, wfi_word, 1'b0, 1'b1);
		advance_cycle();
		n = 0;
		while (!halt && n < 8) begin
			apply_inputs(1'b0, '0, 1'b0, 1'b1);
			advance_cycle();
			n++;
		end
		if (!halt) begin
			timeouts++;
			$display("timeout: halt never rose after a WFI was offered");
		end
		// the wfi stays queued while halted so the flush has an entry to clear
		repeat (8) begin
			rng = xorshift(rng);
			apply_inputs(1'b1, addi_word(rng), 1'b0, 1'b0);
			advance_cycle();
		end
		rng = xorshift(rng);
		apply_inputs(1'b1, addi_word(rng), 1'b1, 1'b0);
		advance_cycle();
		check_levels(2'b00, {full, head_valid});
		rng = xorshift(rng);
		apply_inputs(1'b1, addi_word(rng), 1'b0, 1'b0);
		advance_cycle();
		apply_inputs(1'b0, '0, 1'b0, 1'b1);
		advance_cycle();
		advance_cycle();

		$display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`include "sys_defs.svh"

module decode_stage (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      in_valid,
	input  decode_pkg::inst_t         inst,
	input  logic [`XLEN-1:0]          in_pc,
	input  logic                      flush,
	input  logic                      dispatch_en,
	output logic                      full,
	output logic                      head_valid,
	output decode_pkg::decoded_pack_t head,
	output logic                      csr_op,
	output logic                      halt,
	output logic                      illegal
);

	decode_pkg::decoded_pack_t dec_pack;
	logic dec_ok;
	logic dec_csr;
	logic dec_wfi;
	logic dec_bad;
	logic halted;
	logic accept;
	logic push;
	logic pop;

	decoder u_decoder (
		.in_valid  (in_valid),
		.inst      (inst),
		.in_pc     (in_pc),
		.pack      (dec_pack),
		.decode_ok (dec_ok),
		.csr       (dec_csr),
		.wfi       (dec_wfi),
		.bad       (dec_bad)
	);

	// fetch holds its word until a cycle where all of these allow it
	assign accept = in_valid & ~full & ~halted & ~flush;
	// illegal words are consumed but never queued
	assign push = accept & dec_ok;
	assign pop = dispatch_en & head_valid;

	decode_queue u_queue (
		.clock      (clock),
		.rst_n      (rst_n),
		.flush      (flush),
		.push       (push),
		.push_pack  (dec_pack),
		.pop        (pop),
		.full       (full),
		.head_valid (head_valid),
		.head       (head)
	);

	// status pulses last one cycle after the accepting edge
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			halted <= 1'b0;
			csr_op <= 1'b0;
			halt <= 1'b0;
			illegal <= 1'b0;
		end else begin
			csr_op <= accept & dec_csr;
			halt <= accept & dec_wfi;
			illegal <= accept & dec_bad;
			// stays halted after wfi until the next flush
			if (flush)
				halted <= 1'b0;
			else if (accept & dec_wfi)
				halted <= 1'b1;
		end
	end

endmodule

// ==== src/decode_queue.sv ====
`timescale 1ns/1ps
`include "sys_defs.svh"

// push is already gated by full and pop by head_valid upstream
module decode_queue (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      flush,
	input  logic                      push,
	input  decode_pkg::decoded_pack_t push_pack,
	input  logic                      pop,
	output logic                      full,
	output logic                      head_valid,
	output decode_pkg::decoded_pack_t head
);

	localparam int PTR_W = $clog2(`DQ_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	decode_pkg::decoded_pack_t entries [`DQ_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + PTR_W'(1);
			if (pop)
				rd_ptr <= rd_ptr + PTR_W'(1);
			case ({push, pop})
				2'b10: count <= count + CNT_W'(1);
				2'b01: count <= count - CNT_W'(1);
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			entries[wr_ptr] <= push_pack;
	end

	assign full = (count == CNT_W'(`DQ_DEPTH));
	assign head_valid = (count != '0);
	// oldest entry sits at the read pointer
	assign head = entries[rd_ptr];

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/1ps
`include "sys_defs.svh"

// purely combinational, the stage decides what gets queued
module decoder (
	input  logic                      in_valid,
	input  decode_pkg::inst_t         inst,
	input  logic [`XLEN-1:0]          in_pc,
	output decode_pkg::decoded_pack_t pack,
	output logic                      decode_ok,
	output logic                      csr,
	output logic                      wfi,
	output logic                      bad
);

	decode_pkg::imm_fmt_e imm_fmt;
	decode_pkg::fu_e      fu;
	decode_pkg::func_e    func;
	logic [`XLEN-1:0]     imm;
	logic                 r_fmt;
	logic                 pc_use;
	logic                 is_csr;
	logic                 is_wfi;
	logic                 unknown;

	imm_gen u_imm_gen (
		.inst    (inst),
		.imm_fmt (imm_fmt),
		.imm     (imm)
	);

	// unit, operand format and pc use follow the major opcode
	always_comb begin
		imm_fmt = decode_pkg::IMM_NONE;
		fu = decode_pkg::FU_ALU;
		r_fmt = 1'b0;
		pc_use = 1'b0;
		case (inst.r.opcode)
			`OPC_LUI: imm_fmt = decode_pkg::IMM_U;
			`OPC_AUIPC: begin
				imm_fmt = decode_pkg::IMM_U;
				pc_use = 1'b1;
			end
			`OPC_JAL: begin
				fu = decode_pkg::FU_BTU;
				imm_fmt = decode_pkg::IMM_J;
				pc_use = 1'b1;
			end
			`OPC_JALR: begin
				fu = decode_pkg::FU_BTU;
				imm_fmt = decode_pkg::IMM_I;
				pc_use = 1'b1;
			end
			`OPC_BRANCH: begin
				fu = decode_pkg::FU_BTU;
				imm_fmt = decode_pkg::IMM_B;
				pc_use = 1'b1;
			end
			`OPC_LOAD: begin
				fu = decode_pkg::FU_LSU;
				imm_fmt = decode_pkg::IMM_I;
			end
			`OPC_STORE: begin
				fu = decode_pkg::FU_LSU;
				imm_fmt = decode_pkg::IMM_S;
			end
			`OPC_OP_IMM: imm_fmt = decode_pkg::IMM_I;
			`OPC_OP: begin
				r_fmt = 1'b1;
				// funct7 bit 0 marks the M extension
				if (inst.r.funct7[0])
					fu = decode_pkg::FU_MULT;
			end
			`OPC_SYSTEM: begin
				fu = decode_pkg::FU_SYS;
				// csr forms carry rs1, rd and the csr address but wfi has no operands
				if (inst.i.funct3 != 3'b000)
					imm_fmt = decode_pkg::IMM_I;
			end
			default: ;
		endcase
	end

	// exact match on the whole word picks the operation and legality
	always_comb begin
		func = decode_pkg::ALU_ADD;
		is_csr = 1'b0;
		is_wfi = 1'b0;
		unknown = 1'b0;
		casez (inst)
			`RV32_LUI, `RV32_AUIPC, `RV32_ADDI, `RV32_ADD:
				func = decode_pkg::ALU_ADD;
			`RV32_SUB: func = decode_pkg::ALU_SUB;
			`RV32_SLTI, `RV32_SLT: func = decode_pkg::ALU_SLT;
			`RV32_SLTIU, `RV32_SLTU: func = decode_pkg::ALU_SLTU;
			`RV32_ANDI, `RV32_AND: func = decode_pkg::ALU_AND;
			`RV32_ORI, `RV32_OR: func = decode_pkg::ALU_OR;
			`RV32_XORI, `RV32_XOR: func = decode_pkg::ALU_XOR;
			`RV32_SLLI, `RV32_SLL: func = decode_pkg::ALU_SLL;
			`RV32_SRLI, `RV32_SRL: func = decode_pkg::ALU_SRL;
			`RV32_SRAI, `RV32_SRA: func = decode_pkg::ALU_SRA;
			`RV32_JAL: func = decode_pkg::BTU_JAL;
			`RV32_JALR: func = decode_pkg::BTU_JALR;
			`RV32_BEQ: func = decode_pkg::BTU_BEQ;
			`RV32_BNE: func = decode_pkg::BTU_BNE;
			`RV32_BLT: func = decode_pkg::BTU_BLT;
			`RV32_BGE: func = decode_pkg::BTU_BGE;
			`RV32_BLTU: func = decode_pkg::BTU_BLTU;
			`RV32_BGEU: func = decode_pkg::BTU_BGEU;
			`RV32_LB: func = decode_pkg::LSU_LB;
			`RV32_LH: func = decode_pkg::LSU_LH;
			`RV32_LW: func = decode_pkg::LSU_LW;
			`RV32_LBU: func = decode_pkg::LSU_LBU;
			`RV32_LHU: func = decode_pkg::LSU_LHU;
			`RV32_SB: func = decode_pkg::LSU_SB;
			`RV32_SH: func = decode_pkg::LSU_SH;
			`RV32_SW: func = decode_pkg::LSU_SW;
			`RV32_MUL: func = decode_pkg::MULT_MUL;
			`RV32_MULH: func = decode_pkg::MULT_MULH;
			`RV32_MULHSU: func = decode_pkg::MULT_MULHSU;
			`RV32_MULHU: func = decode_pkg::MULT_MULHU;
			`RV32_CSRRW, `RV32_CSRRS, `RV32_CSRRC: is_csr = 1'b1;
			`RV32_WFI: is_wfi = 1'b1;
			// divides fall through to here as well
			default: unknown = 1'b1;
		endcase
	end

	// register fields and valid flags come from the operand format
	always_comb begin
		pack = '0;
		pack.pc = in_pc;
		pack.imm = imm;
		pack.fu = fu;
		pack.func = func;
		pack.imm_valid = (imm_fmt != decode_pkg::IMM_NONE);
		pack.pc_valid = pc_use;
		if (r_fmt) begin
			pack.arch_reg.src1 = inst.r.rs1;
			pack.arch_reg.src2 = inst.r.rs2;
			pack.arch_reg.dest = inst.r.rd;
			pack.rs1_valid = 1'b1;
			pack.rs2_valid = 1'b1;
		end else begin
			case (imm_fmt)
				decode_pkg::IMM_I: begin
					pack.arch_reg.src1 = inst.i.rs1;
					pack.arch_reg.dest = inst.i.rd;
					pack.rs1_valid = 1'b1;
				end
				decode_pkg::IMM_S: begin
					pack.arch_reg.src1 = inst.s.rs1;
					pack.arch_reg.src2 = inst.s.rs2;
					pack.rs1_valid = 1'b1;
					pack.rs2_valid = 1'b1;
				end
				decode_pkg::IMM_B: begin
					pack.arch_reg.src1 = inst.b.rs1;
					pack.arch_reg.src2 = inst.b.rs2;
					pack.rs1_valid = 1'b1;
					pack.rs2_valid = 1'b1;
				end
				decode_pkg::IMM_U: pack.arch_reg.dest = inst.u.rd;
				decode_pkg::IMM_J: pack.arch_reg.dest = inst.j.rd;
				default: ;
			endcase
		end
	end

	assign bad = in_valid & unknown;
	assign csr = in_valid & is_csr;
	assign wfi = in_valid & is_wfi;
	assign decode_ok = in_valid & ~bad;

endmodule

// ==== src/imm_gen.sv ====
`timescale 1ns/1ps
`include "sys_defs.svh"

module imm_gen (
	input  decode_pkg::inst_t    inst,
	input  decode_pkg::imm_fmt_e imm_fmt,
	output logic [`XLEN-1:0]     imm
);

	always_comb begin
		case (imm_fmt)
			decode_pkg::IMM_I:
				imm = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
			decode_pkg::IMM_S:
				imm = {{(`XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
			// branch offsets are even so bit 0 is implied
			decode_pkg::IMM_B:
				imm = {
					{(`XLEN-12){inst.b.imm12}},
					inst.b.imm11,
					inst.b.imm10_5,
					inst.b.imm4_1,
					1'b0
				};
			// upper immediate fills 31:12 and leaves the low bits clear
			decode_pkg::IMM_U:
				imm = {inst.u.imm, 12'b0};
			decode_pkg::IMM_J:
				imm = {
					{(`XLEN-20){inst.j.imm20}},
					inst.j.imm19_12,
					inst.j.imm11,
					inst.j.imm10_1,
					1'b0
				};
			default:
				imm = '0;
		endcase
	end

endmodule

// ==== src/decode_pkg.sv ====
`include "sys_defs.svh"

package decode_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	// store offset is split around rs2 and rs1
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_type_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_type_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_type_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_type_t;

	// one fetched word, read through whichever format view applies
	typedef union packed {
		r_type_t r;
		i_type_t i;
		s_type_t s;
		b_type_t b;
		u_type_t u;
		j_type_t j;
	} inst_t;

	typedef enum logic [2:0] {
		IMM_NONE,
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J
	} imm_fmt_e;

	typedef enum logic [2:0] {
		FU_ALU,
		FU_BTU,
		FU_LSU,
		FU_MULT,
		FU_SYS
	} fu_e;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
		ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
		BTU_JAL, BTU_JALR, BTU_BEQ, BTU_BNE,
		BTU_BLT, BTU_BGE, BTU_BLTU, BTU_BGEU,
		LSU_LB, LSU_LH, LSU_LW, LSU_LBU,
		LSU_LHU, LSU_SB, LSU_SH, LSU_SW,
		MULT_MUL, MULT_MULH, MULT_MULHSU, MULT_MULHU
	} func_e;

	typedef struct packed {
		logic [4:0] src1;
		logic [4:0] src2;
		logic [4:0] dest;
	} arch_reg_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		arch_reg_t        arch_reg;
		logic [`XLEN-1:0] imm;
		fu_e              fu;
		func_e            func;
		logic             rs1_valid;
		logic             rs2_valid;
		logic             imm_valid;
		logic             pc_valid;
	} decoded_pack_t;

endpackage

// ==== include/sys_defs.svh ====
`ifndef SYS_DEFS_SVH
`define SYS_DEFS_SVH

// machine word width
`define XLEN 32

// entries in the decoded instruction queue, kept a power of two
`define DQ_DEPTH 8

// major opcodes
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011
`define OPC_SYSTEM 7'b1110011

// whole word patterns for casez, laid out as funct7 rs2 rs1 funct3 rd opcode
`define RV32_LUI    32'b???????_?????_?????_???_?????_0110111
`define RV32_AUIPC  32'b???????_?????_?????_???_?????_0010111
`define RV32_JAL    32'b???????_?????_?????_???_?????_1101111
`define RV32_JALR   32'b???????_?????_?????_000_?????_1100111
`define RV32_BEQ    32'b???????_?????_?????_000_?????_1100011
`define RV32_BNE    32'b???????_?????_?????_001_?????_1100011
`define RV32_BLT    32'b???????_?????_?????_100_?????_1100011
`define RV32_BGE    32'b???????_?????_?????_101_?????_1100011
`define RV32_BLTU   32'b???????_?????_?????_110_?????_1100011
`define RV32_BGEU   32'b???????_?????_?????_111_?????_1100011
`define RV32_LB     32'b???????_?????_?????_000_?????_0000011
`define RV32_LH     32'b???????_?????_?????_001_?????_0000011
`define RV32_LW     32'b???????_?????_?????_010_?????_0000011
`define RV32_LBU    32'b???????_?????_?????_100_?????_0000011
`define RV32_LHU    32'b???????_?????_?????_101_?????_0000011
`define RV32_SB     32'b???????_?????_?????_000_?????_0100011
`define RV32_SH     32'b???????_?????_?????_001_?????_0100011
`define RV32_SW     32'b???????_?????_?????_010_?????_0100011
`define RV32_ADDI   32'b???????_?????_?????_000_?????_0010011
`define RV32_SLTI   32'b???????_?????_?????_010_?????_0010011
`define RV32_SLTIU  32'b???????_?????_?????_011_?????_0010011
`define RV32_XORI   32'b???????_?????_?????_100_?????_0010011
`define RV32_ORI    32'b???????_?????_?????_110_?????_0010011
`define RV32_ANDI   32'b???????_?????_?????_111_?????_0010011
`define RV32_SLLI   32'b0000000_?????_?????_001_?????_0010011
`define RV32_SRLI   32'b0000000_?????_?????_101_?????_0010011
`define RV32_SRAI   32'b0100000_?????_?????_101_?????_0010011
`define RV32_ADD    32'b0000000_?????_?????_000_?????_0110011
`define RV32_SUB    32'b0100000_?????_?????_000_?????_0110011
`define RV32_SLL    32'b0000000_?????_?????_001_?????_0110011
`define RV32_SLT    32'b0000000_?????_?????_010_?????_0110011
`define RV32_SLTU   32'b0000000_?????_?????_011_?????_0110011
`define RV32_XOR    32'b0000000_?????_?????_100_?????_0110011
`define RV32_SRL    32'b0000000_?????_?????_101_?????_0110011
`define RV32_SRA    32'b0100000_?????_?????_101_?????_0110011
`define RV32_OR     32'b0000000_?????_?????_110_?????_0110011
`define RV32_AND    32'b0000000_?????_?????_111_?????_0110011
`define RV32_MUL    32'b0000001_?????_?????_000_?????_0110011
`define RV32_MULH   32'b0000001_?????_?????_001_?????_0110011
`define RV32_MULHSU 32'b0000001_?????_?????_010_?????_0110011
`define RV32_MULHU  32'b0000001_?????_?????_011_?????_0110011
`define RV32_CSRRW  32'b???????_?????_?????_001_?????_1110011
`define RV32_CSRRS  32'b???????_?????_?????_010_?????_1110011
`define RV32_CSRRC  32'b???????_?????_?????_011_?????_1110011
`define RV32_WFI    32'b0001000_00101_00000_000_00000_1110011

`endif
